/* rtl/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data path and address width
`define EX_DATA_W 32

// Architectural register index width
`define EX_REG_ADDR_W 5

// Memory-stage slots checked for load forwarding, highest index is youngest
`define EX_FWD_PORTS 2

// Fetch-target-queue id width
`define EX_FTQ_ID_W 3

`endif

/* rtl/ex_pkg.sv */
`include "ex_macros.svh"

package ex_pkg;

    typedef logic [`EX_DATA_W-1:0]     word_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EX_FTQ_ID_W-1:0]   ftq_id_t;

    typedef enum logic [5:0] {
        // Arithmetic and logic
        ADD, SUB, SLT, SLTU, AND, OR, XOR, NOR, ORN, ANDN,
        SLL, SRL, SRA, LUI, PCADD,
        // Iterative unit
        MUL, MULH, MULHU, DIV, DIVU, MOD, MODU,
        // Control flow
        B, BL, JIRL, BEQ, BNE, BLT, BGE, BLTU, BGEU,
        // Memory access
        LD_B, LD_H, LD_W, ST_B, ST_H, ST_W,
        NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } muldiv_state_e;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   op;
        reg_addr_t raddr0;
        reg_addr_t raddr1;
        reg_addr_t rd_addr;
        logic      rd_we;
        word_t     operand1;
        word_t     operand2;
        word_t     imm;
        logic      use_imm;
        ftq_id_t   ftq_id;
        logic      excp;
    } dispatch_ex_t;

    typedef struct packed {
        logic      we;
        logic      is_load;
        reg_addr_t addr;
        word_t     data;
    } mem_fwd_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   op;
        reg_addr_t rd_addr;
        logic      rd_we;
        word_t     wdata;
        word_t     mem_addr;
        word_t     store_data;
        logic      excp;
        logic      misaligned;
    } ex_mem_t;

    typedef struct packed {
        logic      rd_we;
        reg_addr_t rd_addr;
        word_t     wdata;
    } ex_fwd_t;

    typedef struct packed {
        logic    taken;
        word_t   target;
        ftq_id_t ftq_id;
    } branch_t;

endpackage

/* rtl/ex_operand_fwd.sv */
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_operand_fwd (
    input  ex_pkg::dispatch_ex_t                    dispatch_i,
    input  ex_pkg::mem_fwd_t [`EX_FWD_PORTS-1:0]    mem_fwd_i,
    output ex_pkg::word_t                           src1_o,
    output ex_pkg::word_t                           src2_o,
    output ex_pkg::word_t                           raw2_o
);

    ex_pkg::word_t op1;
    ex_pkg::word_t op2;

    // Later slots are younger, so a later match overrides an earlier one
    function automatic ex_pkg::word_t pick(input ex_pkg::reg_addr_t addr,
                                           input ex_pkg::word_t     dflt);
        ex_pkg::word_t val;
        val = dflt;
        for (int i = 0; i < `EX_FWD_PORTS; i++) begin
            if (mem_fwd_i[i].we && mem_fwd_i[i].is_load &&
                mem_fwd_i[i].addr == addr && addr != '0) begin
                val = mem_fwd_i[i].data;
            end
        end
        return val;
    endfunction

    always_comb begin
        op1 = pick(dispatch_i.raddr0, dispatch_i.operand1);
        op2 = pick(dispatch_i.raddr1, dispatch_i.operand2);
    end

    assign src1_o = op1;
    assign src2_o = dispatch_i.use_imm ? dispatch_i.imm : op2;
    // Branch compares and store data need the register value
    assign raw2_o = op2;

endmodule

/* rtl/ex_alu.sv */
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_alu (
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   pc_i,
    input  ex_pkg::word_t   imm_i,
    input  ex_pkg::word_t   src1_i,
    input  ex_pkg::word_t   src2_i,
    output ex_pkg::word_t   result_o,
    output ex_pkg::word_t   mem_addr_o
);

    logic [4:0] shamt;

    assign shamt = src2_i[4:0];

    always_comb begin
        case (op_i)
            ex_pkg::ADD: begin
                result_o = src1_i + src2_i;
            end
            ex_pkg::SUB: begin
                result_o = src1_i - src2_i;
            end
            ex_pkg::SLT: begin
                result_o = ex_pkg::word_t'($signed(src1_i) < $signed(src2_i));
            end
            ex_pkg::SLTU: begin
                result_o = ex_pkg::word_t'(src1_i < src2_i);
            end
            ex_pkg::AND:  result_o = src1_i & src2_i;
            ex_pkg::OR:   result_o = src1_i | src2_i;
            ex_pkg::XOR:  result_o = src1_i ^ src2_i;
            ex_pkg::NOR:  result_o = ~(src1_i | src2_i);
            ex_pkg::ORN:  result_o = src1_i | ~src2_i;
            ex_pkg::ANDN: result_o = src1_i & ~src2_i;
            ex_pkg::SLL: begin
                result_o = src1_i << shamt;
            end
            ex_pkg::SRL: begin
                result_o = src1_i >> shamt;
            end
            ex_pkg::SRA: begin
                // Sign bit fills from the left
                result_o = $signed(src1_i) >>> shamt;
            end
            ex_pkg::LUI: begin
                // Upper immediate arrives already shifted
                result_o = src2_i;
            end
            ex_pkg::PCADD: begin
                result_o = pc_i + src2_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    // Base register plus offset for loads and stores
    assign mem_addr_o = src1_i + imm_i;

    // Shift amount covers exactly one data word
    if ($bits(shamt) != $clog2(`EX_DATA_W)) begin : g_shamt_chk
        $error("ex_alu shift amount width does not match the data width");
    end

endmodule

/* rtl/ex_branch.sv */
`timescale 1ns/10ps

module ex_branch (
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   pc_i,
    input  ex_pkg::word_t   imm_i,
    input  ex_pkg::word_t   src1_i,
    input  ex_pkg::word_t   raw2_i,
    input  ex_pkg::ftq_id_t ftq_id_i,
    input  logic            valid_i,
    output ex_pkg::branch_t branch_o
);

    logic cond;

    always_comb begin
        case (op_i)
            ex_pkg::B, ex_pkg::BL, ex_pkg::JIRL: begin
                cond = 1'b1;
            end
            ex_pkg::BEQ:  cond = src1_i == raw2_i;
            ex_pkg::BNE:  cond = src1_i != raw2_i;
            ex_pkg::BLT:  cond = $signed(src1_i) < $signed(raw2_i);
            ex_pkg::BGE:  cond = $signed(src1_i) >= $signed(raw2_i);
            ex_pkg::BLTU: cond = src1_i < raw2_i;
            ex_pkg::BGEU: cond = src1_i >= raw2_i;
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    always_comb begin
        branch_o.taken = valid_i && cond;
        // Register-indirect jump, everything else is pc-relative
        if (op_i == ex_pkg::JIRL) begin
            branch_o.target = src1_i + imm_i;
        end else begin
            branch_o.target = pc_i + imm_i;
        end
        branch_o.ftq_id = branch_o.taken ? ftq_id_i : '0;
    end

endmodule

/* rtl/ex_muldiv.sv */
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_muldiv (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            start_i,
    input  logic            ack_i,
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   src1_i,
    input  ex_pkg::word_t   src2_i,
    output logic            done_o,
    output ex_pkg::word_t   result_o
);

    localparam int W = `EX_DATA_W;

    ex_pkg::muldiv_state_e state_q;
    logic [$clog2(W)-1:0]  cnt_q;
    ex_pkg::alu_op_e       op_q;
    ex_pkg::word_t         hi_q;
    ex_pkg::word_t         lo_q;
    ex_pkg::word_t         opnd_q;
    logic                  neg_q;
    logic                  neg_rem_q;
    logic                  div_zero_q;

    logic            is_signed;
    logic            is_div;
    logic            run_div;
    logic            neg_a;
    logic            neg_b;
    ex_pkg::word_t   a_mag;
    ex_pkg::word_t   b_mag;
    logic [W:0]      add_sum;
    logic [W:0]      div_shift;
    logic [W:0]      div_trial;
    logic [2*W-1:0]  prod_fix;

    always_comb begin
        is_signed = op_i inside {ex_pkg::MUL, ex_pkg::MULH, ex_pkg::DIV, ex_pkg::MOD};
        is_div    = op_i inside {ex_pkg::DIV, ex_pkg::DIVU, ex_pkg::MOD, ex_pkg::MODU};
        run_div   = op_q inside {ex_pkg::DIV, ex_pkg::DIVU, ex_pkg::MOD, ex_pkg::MODU};
        neg_a     = is_signed && src1_i[W-1];
        neg_b     = is_signed && src2_i[W-1];
        a_mag     = neg_a ? -src1_i : src1_i;
        b_mag     = neg_b ? -src2_i : src2_i;
        // One shift-add step, multiplier bits leave lo from the bottom
        add_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, opnd_q} : '0);
        // One restoring step, dividend bits enter the remainder from lo
        div_shift = {hi_q, lo_q[W-1]};
        div_trial = div_shift - {1'b0, opnd_q};
        prod_fix  = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            state_q <= ex_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ex_pkg::IDLE: begin
                    if (start_i) begin
                        state_q <= ex_pkg::RUN;
                        cnt_q   <= '0;
                    end
                end
                ex_pkg::RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == W - 1) begin
                        state_q <= ex_pkg::DONE;
                    end
                end
                ex_pkg::DONE: begin
                    if (ack_i) begin
                        state_q <= ex_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= ex_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ex_pkg::IDLE && start_i) begin
            op_q       <= op_i;
            opnd_q     <= b_mag;
            neg_q      <= neg_a ^ neg_b;
            neg_rem_q  <= neg_a;
            div_zero_q <= is_div && src2_i == '0;
            // Zero divisor keeps the dividend in both halves
            hi_q       <= (is_div && src2_i == '0) ? a_mag : '0;
            lo_q       <= a_mag;
        end else if (state_q == ex_pkg::RUN && !div_zero_q) begin
            if (run_div) begin
                if (!div_trial[W]) begin
                    hi_q <= div_trial[W-1:0];
                    lo_q <= {lo_q[W-2:0], 1'b1};
                end else begin
                    hi_q <= div_shift[W-1:0];
                    lo_q <= {lo_q[W-2:0], 1'b0};
                end
            end else begin
                hi_q <= add_sum[W:1];
                lo_q <= {add_sum[0], lo_q[W-1:1]};
            end
        end
    end

    always_comb begin
        case (op_q)
            ex_pkg::MUL:                result_o = prod_fix[W-1:0];
            ex_pkg::MULH, ex_pkg::MULHU: result_o = prod_fix[2*W-1:W];
            ex_pkg::DIV, ex_pkg::DIVU:  result_o = neg_q ? -lo_q : lo_q;
            default:                    result_o = neg_rem_q ? -hi_q : hi_q;
        endcase
    end

    assign done_o = state_q == ex_pkg::DONE;

    // Stage-side busy tracking must agree with the FSM
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start_i |-> state_q == ex_pkg::IDLE);

endmodule

/* rtl/ex_stage.sv */
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  ex_pkg::dispatch_ex_t                 dispatch_i,
    input  ex_pkg::mem_fwd_t [`EX_FWD_PORTS-1:0] mem_fwd_i,
    input  logic                                 stall_i,
    input  logic                                 flush_i,
    output ex_pkg::ex_mem_t                      ex_mem_o,
    output ex_pkg::ex_fwd_t                      ex_fwd_o,
    output ex_pkg::branch_t                      branch_o,
    output logic                                 stallreq_o
);

    ex_pkg::word_t   src1;
    ex_pkg::word_t   src2;
    ex_pkg::word_t   raw2;
    ex_pkg::word_t   alu_result;
    ex_pkg::word_t   mem_addr;
    ex_pkg::word_t   md_result;
    logic            md_done;
    logic            md_start;
    logic            md_ack;
    logic            md_busy_q;
    logic            is_muldiv;
    logic            is_link;
    logic            is_load;
    logic            is_store;
    logic            is_half;
    logic            is_word;
    logic            misaligned;
    ex_pkg::ex_mem_t cur;
    ex_pkg::ex_mem_t nxt;

    ex_operand_fwd u_fwd (
        .dispatch_i (dispatch_i),
        .mem_fwd_i  (mem_fwd_i),
        .src1_o     (src1),
        .src2_o     (src2),
        .raw2_o     (raw2)
    );

    ex_alu u_alu (
        .op_i       (dispatch_i.op),
        .pc_i       (dispatch_i.pc),
        .imm_i      (dispatch_i.imm),
        .src1_i     (src1),
        .src2_i     (src2),
        .result_o   (alu_result),
        .mem_addr_o (mem_addr)
    );

    ex_branch u_branch (
        .op_i     (dispatch_i.op),
        .pc_i     (dispatch_i.pc),
        .imm_i    (dispatch_i.imm),
        .src1_i   (src1),
        .raw2_i   (raw2),
        .ftq_id_i (dispatch_i.ftq_id),
        .valid_i  (dispatch_i.valid),
        .branch_o (branch_o)
    );

    ex_muldiv u_muldiv (
        .clk      (clk),
        .rst      (rst),
        .flush_i  (flush_i),
        .start_i  (md_start),
        .ack_i    (md_ack),
        .op_i     (dispatch_i.op),
        .src1_i   (src1),
        .src2_i   (src2),
        .done_o   (md_done),
        .result_o (md_result)
    );

    // Result class from the opcode
    always_comb begin
        is_muldiv = 1'b0;
        is_link   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_half   = 1'b0;
        is_word   = 1'b0;
        case (dispatch_i.op)
            ex_pkg::MUL, ex_pkg::MULH, ex_pkg::MULHU, ex_pkg::DIV,
            ex_pkg::DIVU, ex_pkg::MOD, ex_pkg::MODU: begin
                is_muldiv = 1'b1;
            end
            ex_pkg::BL, ex_pkg::JIRL: begin
                is_link = 1'b1;
            end
            ex_pkg::LD_B: begin
                is_load = 1'b1;
            end
            ex_pkg::LD_H: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            ex_pkg::LD_W: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            ex_pkg::ST_B: begin
                is_store = 1'b1;
            end
            ex_pkg::ST_H: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            ex_pkg::ST_W: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: begin
                is_muldiv = 1'b0;
            end
        endcase
    end

    // Unit is started once per instruction and released when the result is taken
    assign md_start   = dispatch_i.valid && is_muldiv && !md_busy_q && !stall_i;
    assign md_ack     = dispatch_i.valid && is_muldiv && md_done && !stall_i;
    assign stallreq_o = dispatch_i.valid && is_muldiv && !md_done;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            md_busy_q <= 1'b0;
        end else if (md_start) begin
            md_busy_q <= 1'b1;
        end else if (md_ack) begin
            md_busy_q <= 1'b0;
        end
    end

    // Byte accesses are always aligned
    assign misaligned = (is_word && mem_addr[1:0] != 2'b00) || (is_half && mem_addr[0]);

    always_comb begin
        cur            = '0;
        cur.valid      = dispatch_i.valid;
        cur.pc         = dispatch_i.pc;
        cur.op         = dispatch_i.op;
        cur.rd_addr    = dispatch_i.rd_addr;
        cur.rd_we      = dispatch_i.rd_we && !is_store;
        cur.mem_addr   = mem_addr;
        cur.store_data = is_store ? raw2 : '0;
        cur.misaligned = misaligned;
        cur.excp       = dispatch_i.excp || misaligned;
        if (is_muldiv) begin
            cur.wdata = md_result;
        end else if (is_link) begin
            cur.wdata = dispatch_i.pc + ex_pkg::word_t'(4);
        end else if (is_load || is_store) begin
            cur.wdata = '0;
        end else begin
            cur.wdata = alu_result;
        end
    end

    // Bubble while the iterative unit is still working
    assign nxt = stallreq_o ? '0 : cur;

    assign ex_fwd_o.rd_we   = nxt.valid && nxt.rd_we;
    assign ex_fwd_o.rd_addr = nxt.rd_addr;
    assign ex_fwd_o.wdata   = nxt.wdata;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            ex_mem_o <= '0;
        end else if (!stall_i) begin
            ex_mem_o <= nxt;
        end
    end

    a_flush_kills: assert property (@(posedge clk) disable iff (rst)
        $past(flush_i) |-> !ex_mem_o.valid);

endmodule

/* testbench/tb_ex_stage.sv */
`timescale 1ns/10ps
`include "ex_macros.svh"

module tb_ex_stage;

    localparam int N_ALU   = 200;
    localparam int N_FWD   = 100;
    localparam int N_BR    = 100;
    localparam int N_MEM   = 100;
    localparam int N_MD    = 40;
    localparam int N_STALL = 20;
    localparam int N_FLUSH = 10;
    localparam int N_TOTAL = N_ALU + N_FWD + N_BR + N_MEM + N_MD + 2 * N_STALL + 3 * N_FLUSH;
    // Longest wait for the iterative unit
    localparam int MD_LIMIT = 100;

    logic                                 clk;
    logic                                 rst;
    ex_pkg::dispatch_ex_t                 disp;
    ex_pkg::mem_fwd_t [`EX_FWD_PORTS-1:0] fwd;
    logic                                 stall_i;
    logic                                 flush_i;
    ex_pkg::ex_mem_t                      ex_mem_o;
    ex_pkg::ex_fwd_t                      ex_fwd_o;
    ex_pkg::branch_t                      branch_o;
    logic                                 stallreq_o;
    logic [31:0]                          seed;

    ex_stage UUT (
        .clk        (clk),
        .rst        (rst),
        .dispatch_i (disp),
        .mem_fwd_i  (fwd),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .ex_mem_o   (ex_mem_o),
        .ex_fwd_o   (ex_fwd_o),
        .branch_o   (branch_o),
        .stallreq_o (stallreq_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic ex_pkg::alu_op_e pick_op(input int first, input int count);
        logic [5:0] code;
        code = 6'(first) + 6'(next_rand() % count);
        return ex_pkg::alu_op_e'(code);
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("ERROR: time %0t, %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR: time %0t, %s = %h, expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Youngest matching load slot wins and register 0 never forwards
    function automatic ex_pkg::word_t fwd_pick(input ex_pkg::reg_addr_t addr,
                                               input ex_pkg::word_t     dflt);
        if (addr != '0 && fwd[1].we && fwd[1].is_load && fwd[1].addr == addr) begin
            return fwd[1].data;
        end
        if (addr != '0 && fwd[0].we && fwd[0].is_load && fwd[0].addr == addr) begin
            return fwd[0].data;
        end
        return dflt;
    endfunction

    function automatic ex_pkg::word_t result_model(input ex_pkg::alu_op_e op,
                                                   input ex_pkg::word_t   pc,
                                                   input ex_pkg::word_t   a,
                                                   input ex_pkg::word_t   b);
        longint      sa;
        longint      sb;
        longint      full;
        logic [63:0] ufull;
        sa    = longint'($signed(a));
        sb    = longint'($signed(b));
        full  = sa * sb;
        ufull = {32'b0, a} * {32'b0, b};
        // Zero divisor returns the dividend for quotient and remainder
        if (b == '0 && op inside {ex_pkg::DIV, ex_pkg::DIVU, ex_pkg::MOD, ex_pkg::MODU}) begin
            return a;
        end
        case (op)
            ex_pkg::ADD:   return a + b;
            ex_pkg::SUB:   return a - b;
            ex_pkg::SLT:   return ex_pkg::word_t'($signed(a) < $signed(b));
            ex_pkg::SLTU:  return ex_pkg::word_t'(a < b);
            ex_pkg::AND:   return a & b;
            ex_pkg::OR:    return a | b;
            ex_pkg::XOR:   return a ^ b;
            ex_pkg::NOR:   return ~(a | b);
            ex_pkg::ORN:   return a | ~b;
            ex_pkg::ANDN:  return a & ~b;
            ex_pkg::SLL:   return a << b[4:0];
            ex_pkg::SRL:   return a >> b[4:0];
            ex_pkg::SRA:   return $signed(a) >>> b[4:0];
            ex_pkg::LUI:   return b;
            ex_pkg::PCADD: return pc + b;
            ex_pkg::MUL:   return ufull[31:0];
            ex_pkg::MULH:  return full[63:32];
            ex_pkg::MULHU: return ufull[63:32];
            ex_pkg::DIV:   return ex_pkg::word_t'(sa / sb);
            ex_pkg::MOD:   return ex_pkg::word_t'(sa % sb);
            ex_pkg::DIVU:  return a / b;
            ex_pkg::MODU:  return a % b;
            default:       return '0;
        endcase
    endfunction

    function automatic ex_pkg::ex_mem_t expected_mem();
        ex_pkg::ex_mem_t e;
        ex_pkg::word_t   a;
        ex_pkg::word_t   raw;
        ex_pkg::word_t   b;
        ex_pkg::word_t   addr;
        logic            st;
        logic            mis;
        a    = fwd_pick(disp.raddr0, disp.operand1);
        raw  = fwd_pick(disp.raddr1, disp.operand2);
        b    = disp.use_imm ? disp.imm : raw;
        addr = a + disp.imm;
        st   = disp.op inside {ex_pkg::ST_B, ex_pkg::ST_H, ex_pkg::ST_W};
        mis  = (disp.op inside {ex_pkg::LD_W, ex_pkg::ST_W} && addr[1:0] != 2'b00) ||
               (disp.op inside {ex_pkg::LD_H, ex_pkg::ST_H} && addr[0]);
        e            = '0;
        e.valid      = disp.valid;
        e.pc         = disp.pc;
        e.op         = disp.op;
        e.rd_addr    = disp.rd_addr;
        e.rd_we      = disp.rd_we && !st;
        e.mem_addr   = addr;
        e.store_data = st ? raw : '0;
        e.misaligned = mis;
        e.excp       = disp.excp || mis;
        if (disp.op inside {ex_pkg::BL, ex_pkg::JIRL}) begin
            e.wdata = disp.pc + 32'd4;
        end else begin
            e.wdata = result_model(disp.op, disp.pc, a, b);
        end
        return e;
    endfunction

    function automatic ex_pkg::branch_t expected_branch();
        ex_pkg::branch_t bt;
        ex_pkg::word_t   a;
        ex_pkg::word_t   raw;
        logic            cond;
        a   = fwd_pick(disp.raddr0, disp.operand1);
        raw = fwd_pick(disp.raddr1, disp.operand2);
        case (disp.op)
            ex_pkg::B, ex_pkg::BL, ex_pkg::JIRL: cond = 1'b1;
            ex_pkg::BEQ:  cond = a == raw;
            ex_pkg::BNE:  cond = a != raw;
            ex_pkg::BLT:  cond = $signed(a) < $signed(raw);
            ex_pkg::BGE:  cond = $signed(a) >= $signed(raw);
            ex_pkg::BLTU: cond = a < raw;
            ex_pkg::BGEU: cond = a >= raw;
            default:      cond = 1'b0;
        endcase
        bt.taken  = disp.valid && cond;
        bt.target = (disp.op == ex_pkg::JIRL) ? a + disp.imm : disp.pc + disp.imm;
        bt.ftq_id = bt.taken ? disp.ftq_id : '0;
        return bt;
    endfunction

    task automatic make_instr(input ex_pkg::alu_op_e op);
        logic [31:0] r;
        r             = next_rand();
        disp          = '0;
        disp.valid    = 1'b1;
        disp.pc       = next_rand() & 32'hffff_fffc;
        disp.op       = op;
        disp.raddr0   = r[4:0];
        disp.raddr1   = r[9:5];
        disp.rd_addr  = r[14:10];
        disp.rd_we    = r[15];
        disp.use_imm  = r[16];
        disp.ftq_id   = r[19:17];
        disp.operand1 = next_rand();
        disp.operand2 = next_rand();
        disp.imm      = next_rand();
        fwd           = '0;
    endtask

    task automatic check_mem(input ex_pkg::ex_mem_t e);
        check("ex_mem_o.valid", ex_mem_o.valid, e.valid);
        check("ex_mem_o.pc", ex_mem_o.pc, e.pc);
        check("ex_mem_o.op", ex_mem_o.op, e.op);
        check("ex_mem_o.rd_addr", ex_mem_o.rd_addr, e.rd_addr);
        check("ex_mem_o.rd_we", ex_mem_o.rd_we, e.rd_we);
        check("ex_mem_o.wdata", ex_mem_o.wdata, e.wdata);
        check("ex_mem_o.mem_addr", ex_mem_o.mem_addr, e.mem_addr);
        check("ex_mem_o.store_data", ex_mem_o.store_data, e.store_data);
        check("ex_mem_o.excp", ex_mem_o.excp, e.excp);
        check("ex_mem_o.misaligned", ex_mem_o.misaligned, e.misaligned);
    endtask

    // Same-cycle outputs first and the registered result one cycle later
    task automatic issue_checked();
        ex_pkg::ex_mem_t e;
        ex_pkg::branch_t bt;
        e  = expected_mem();
        bt = expected_branch();
        #1;
        check("stallreq_o", stallreq_o, 1'b0);
        check("branch_o.taken", branch_o.taken, bt.taken);
        check("branch_o.target", branch_o.target, bt.target);
        check("branch_o.ftq_id", branch_o.ftq_id, bt.ftq_id);
        check("ex_fwd_o.rd_we", ex_fwd_o.rd_we, e.valid && e.rd_we);
        check("ex_fwd_o.rd_addr", ex_fwd_o.rd_addr, e.rd_addr);
        check("ex_fwd_o.wdata", ex_fwd_o.wdata, e.wdata);
        step();
        check_mem(e);
    endtask

    task automatic run_muldiv(input ex_pkg::alu_op_e op);
        ex_pkg::ex_mem_t e;
        logic [31:0]     r;
        int              cycles;
        make_instr(op);
        disp.use_imm = 1'b0;
        r = next_rand();
        if (r[1:0] == 2'd0) begin
            disp.operand2 = '0;
        end else if (r[1:0] == 2'd1) begin
            disp.operand2 = disp.operand2 | 32'h8000_0000;
        end else if (r[1:0] == 2'd2) begin
            disp.operand1 = 32'h8000_0000;
            disp.operand2 = '1;
        end
        e = expected_mem();
        #1;
        check("stallreq_o", stallreq_o, 1'b1);
        cycles = 0;
        while (stallreq_o) begin
            step();
            // Only bubbles leave the stage while the unit works
            check("ex_mem_o.valid", ex_mem_o.valid, 1'b0);
            cycles++;
            if (cycles > MD_LIMIT) begin
                abort_run("stallreq_o stayed high, the multiply or divide never finished");
            end
        end
        step();
        check_mem(e);
    endtask

    task automatic run_stall();
        ex_pkg::ex_mem_t held;
        ex_pkg::ex_mem_t e;
        int              n;
        make_instr(pick_op(ex_pkg::ADD, 15));
        issue_checked();
        held = ex_mem_o;
        make_instr(pick_op(ex_pkg::ADD, 15));
        e       = expected_mem();
        stall_i = 1'b1;
        n       = 1 + int'(next_rand() % 3);
        repeat (n) begin
            step();
            check_mem(held);
        end
        stall_i = 1'b0;
        step();
        check_mem(e);
    endtask

    task automatic run_flush();
        int n;
        make_instr(pick_op(ex_pkg::ADD, 15));
        issue_checked();
        make_instr(pick_op(ex_pkg::ADD, 15));
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        check("ex_mem_o all zero", ex_mem_o == '0, 1'b1);
        // Abort a divide part way through
        make_instr(ex_pkg::DIV);
        n = 2 + int'(next_rand() % 20);
        repeat (n) begin
            step();
            check("stallreq_o", stallreq_o, 1'b1);
        end
        disp.valid = 1'b0;
        flush_i    = 1'b1;
        step();
        flush_i = 1'b0;
        check("ex_mem_o.valid", ex_mem_o.valid, 1'b0);
        run_muldiv(pick_op(ex_pkg::MUL, 7));
    endtask

    initial begin
        #(N_TOTAL * 40 * 4);
        abort_run("watchdog expired before all tests completed");
    end

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        disp    = '0;
        fwd     = '0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        seed    = 32'h38aa;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check("ex_mem_o.valid", ex_mem_o.valid, 1'b0);

        repeat (N_ALU) begin
            make_instr(pick_op(ex_pkg::ADD, 15));
            issue_checked();
        end

        // Small register range so slots collide often
        repeat (N_FWD) begin
            make_instr(ex_pkg::ADD);
            disp.use_imm = 1'b0;
            disp.raddr0  = ex_pkg::reg_addr_t'(next_rand() % 4);
            disp.raddr1  = ex_pkg::reg_addr_t'(next_rand() % 4);
            for (int i = 0; i < `EX_FWD_PORTS; i++) begin
                fwd[i].we      = next_rand() % 4 != 0;
                fwd[i].is_load = next_rand() % 4 != 0;
                fwd[i].addr    = ex_pkg::reg_addr_t'(next_rand() % 4);
                fwd[i].data    = next_rand();
            end
            issue_checked();
        end

        repeat (N_BR) begin
            make_instr(pick_op(ex_pkg::B, 9));
            // Equal operands now and then for BEQ and BGE
            if (next_rand() % 4 == 0) begin
                disp.operand2 = disp.operand1;
            end
            issue_checked();
        end

        repeat (N_MEM) begin
            make_instr(pick_op(ex_pkg::LD_B, 6));
            disp.excp = next_rand() % 4 == 0;
            issue_checked();
        end

        repeat (N_MD) begin
            run_muldiv(pick_op(ex_pkg::MUL, 7));
        end

        repeat (N_STALL) begin
            run_stall();
        end

        repeat (N_FLUSH) begin
            run_flush();
        end

        disp = '0;
        step();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_operand_fwd.sv
rtl/ex_alu.sv
rtl/ex_branch.sv
rtl/ex_muldiv.sv
rtl/ex_stage.sv
testbench/tb_ex_stage.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_ex_stage -o sim_ex_stage

./obj_dir/sim_ex_stage | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "Simulation OK"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi
